//--- armCore.f
+incdir+tests
src/armPkg.sv
src/execMemBus.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/hazardUnit.sv
src/armCore.sv
tests/armCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the armCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f armCore.f --top-module armCoreTb \
    -o armCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/armCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- src/armCore.sv
`timescale 1ns/1ps

module armCore import armPkg::*; (
    input  logic                 CLK,
    input  logic                 rst,
    output logic [dataWidth-1:0] instrAddr,
    input  logic [dataWidth-1:0] instr,
    output logic [dataWidth-1:0] ioAddr,
    output logic [dataWidth-1:0] ioWdata,
    output logic                 ioWe,
    input  logic [dataWidth-1:0] ioRdata
);

    instrWord_t              instrD;
    logic                    stall;
    logic                    bubble;
    logic [regAddrWidth-1:0] ra1D;
    logic [regAddrWidth-1:0] ra2D;
    logic [dataWidth-1:0]    rd1E;
    logic [dataWidth-1:0]    rd2E;
    logic [dataWidth-1:0]    immE;
    logic                    useImmE;
    aluOp_t                  aluOpE;
    logic                    regWriteE;
    logic                    memWriteE;
    logic                    memToRegE;
    logic [regAddrWidth-1:0] wa3E;
    logic [regAddrWidth-1:0] ra1E;
    logic [regAddrWidth-1:0] ra2E;
    fwdSel_t                 fwdA;
    fwdSel_t                 fwdB;
    logic                    fwdStore;
    logic                    regWriteW;
    logic [regAddrWidth-1:0] wa3W;
    logic [dataWidth-1:0]    resultW;

    execMemBus em ();

    fetchStage   fetch   (.*);
    decodeStage  decode  (.*);
    executeStage execute (.*);
    memoryStage  memory  (.*);

    hazardUnit hazard (
        .regWriteM (em.regWrite),
        .wa3M      (em.wa3),
        .ra2M      (em.ra2),
        .memWriteM (em.memWrite),
        .*
    );

endmodule

//--- src/armPkg.sv
package armPkg;

    ////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////

    localparam int dataWidth     = 32;
    localparam int regAddrWidth  = 4;
    localparam int numRegs       = 16;
    localparam int dmemWords     = 256;
    localparam int dmemAddrWidth = $clog2(dmemWords);

    // Upper half-word all ones, everything above is IO
    localparam logic [dataWidth-1:0] ioBase = 32'hFFFF_0000;

    localparam logic [1:0] opClassData = 2'b00;
    localparam logic [1:0] opClassMem  = 2'b01;

    ////////////////////////////////////////////////////////////
    // Opcodes and selects
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        opAnd = 4'b0000,
        opSub = 4'b0010,
        opAdd = 4'b0100,
        opOrr = 4'b1100,
        opMov = 4'b1101
    } aluOp_t;

    typedef enum logic [1:0] {
        fwdNone = 2'b00,
        fwdWb   = 2'b01,
        fwdMem  = 2'b10
    } fwdSel_t;

    // Same word seen as data processing or as load/store
    typedef union packed {
        struct packed {
            logic [3:0]              cond;
            logic [1:0]              opClass;
            logic                    immFlag;
            aluOp_t                  opcode;
            logic                    setFlags;
            logic [regAddrWidth-1:0] rn;
            logic [regAddrWidth-1:0] rd;
            logic [11:0]             operand2;
        } dp;
        struct packed {
            logic [3:0]              cond;
            logic [1:0]              opClass;
            logic                    immNot;
            logic                    pre;
            logic                    up;
            logic                    byteSel;
            logic                    writeBack;
            logic                    load;
            logic [regAddrWidth-1:0] rn;
            logic [regAddrWidth-1:0] rd;
            logic [11:0]             offset;
        } mem;
    } instrWord_t;

    // MOV r0, r0
    localparam instrWord_t nopInstr = 32'hE1A0_0000;

endpackage

//--- src/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import armPkg::*; (
    input  logic                    CLK,
    input  logic                    rst,
    input  instrWord_t              instrD,
    input  logic                    bubble,
    input  logic                    stall,
    input  logic                    regWriteW,
    input  logic [regAddrWidth-1:0] wa3W,
    input  logic [dataWidth-1:0]    resultW,
    output logic [regAddrWidth-1:0] ra1D,
    output logic [regAddrWidth-1:0] ra2D,
    output logic [dataWidth-1:0]    rd1E,
    output logic [dataWidth-1:0]    rd2E,
    output logic [dataWidth-1:0]    immE,
    output logic                    useImmE,
    output aluOp_t                  aluOpE,
    output logic                    regWriteE,
    output logic                    memWriteE,
    output logic                    memToRegE,
    output logic [regAddrWidth-1:0] wa3E,
    output logic [regAddrWidth-1:0] ra1E,
    output logic [regAddrWidth-1:0] ra2E
);

    logic                    regWriteD;
    logic                    memWriteD;
    logic                    memToRegD;
    logic                    useImmD;
    aluOp_t                  aluOpD;
    logic [regAddrWidth-1:0] wa3D;
    logic [dataWidth-1:0]    immD;
    logic [dataWidth-1:0]    rd1D;
    logic [dataWidth-1:0]    rd2D;
    logic [dataWidth-1:0]    regFile [numRegs];

    ////////////////////////////////////////////////////////////
    // Instruction decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        ra1D      = instrD.dp.rn;
        ra2D      = instrD.dp.operand2[3:0];
        wa3D      = instrD.dp.rd;
        immD      = dataWidth'(instrD.dp.operand2[7:0]);
        useImmD   = instrD.dp.immFlag;
        aluOpD    = instrD.dp.opcode;
        regWriteD = 1'b0;
        memWriteD = 1'b0;
        memToRegD = 1'b0;
        case (instrD.dp.opClass)
            opClassData: begin
                // Unsupported opcodes decode as no-ops
                regWriteD = instrD.dp.opcode inside {opAnd, opSub, opAdd, opOrr, opMov};
            end
            opClassMem: begin
                ra2D      = instrD.mem.rd;
                immD      = dataWidth'(instrD.mem.offset);
                useImmD   = 1'b1;
                aluOpD    = instrD.mem.up ? opAdd : opSub;
                regWriteD = instrD.mem.load;
                memWriteD = !instrD.mem.load;
                memToRegD = instrD.mem.load;
            end
            default: begin
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (regWriteW) begin
            regFile[wa3W] <= resultW;
        end
    end

    // Writeback in the same cycle wins over the stored value
    assign rd1D = (regWriteW && wa3W == ra1D) ? resultW : regFile[ra1D];
    assign rd2D = (regWriteW && wa3W == ra2D) ? resultW : regFile[ra2D];

    ////////////////////////////////////////////////////////////
    // Decode/execute register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (rst || bubble) begin
            regWriteE <= 1'b0;
            memWriteE <= 1'b0;
            memToRegE <= 1'b0;
        end else if (!stall) begin
            regWriteE <= regWriteD;
            memWriteE <= memWriteD;
            memToRegE <= memToRegD;
        end
    end

    always_ff @(posedge CLK) begin
        if (!stall) begin
            rd1E    <= rd1D;
            rd2E    <= rd2D;
            immE    <= immD;
            useImmE <= useImmD;
            aluOpE  <= aluOpD;
            wa3E    <= wa3D;
            ra1E    <= ra1D;
            ra2E    <= ra2D;
        end
    end

endmodule

//--- src/execMemBus.sv
`timescale 1ns/1ps

interface execMemBus import armPkg::*; ();

    logic                    regWrite;
    logic                    memWrite;
    logic                    memToReg;
    logic [dataWidth-1:0]    aluOut;
    logic [dataWidth-1:0]    writeData;
    logic [regAddrWidth-1:0] wa3;
    // Source of the store data, for the writeback forward
    logic [regAddrWidth-1:0] ra2;

    modport producer (
        output regWrite,
        output memWrite,
        output memToReg,
        output aluOut,
        output writeData,
        output wa3,
        output ra2
    );

    modport consumer (
        input regWrite,
        input memWrite,
        input memToReg,
        input aluOut,
        input writeData,
        input wa3,
        input ra2
    );

endinterface

//--- src/executeStage.sv
`timescale 1ns/1ps

module executeStage import armPkg::*; (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic [dataWidth-1:0]    rd1E,
    input  logic [dataWidth-1:0]    rd2E,
    input  logic [dataWidth-1:0]    immE,
    input  logic                    useImmE,
    input  aluOp_t                  aluOpE,
    input  logic                    regWriteE,
    input  logic                    memWriteE,
    input  logic                    memToRegE,
    input  logic [regAddrWidth-1:0] wa3E,
    input  logic [regAddrWidth-1:0] ra2E,
    input  fwdSel_t                 fwdA,
    input  fwdSel_t                 fwdB,
    input  logic [dataWidth-1:0]    resultW,
    execMemBus.producer             em
);

    logic [dataWidth-1:0] srcA;
    logic [dataWidth-1:0] srcB;
    logic [dataWidth-1:0] aluB;
    logic [dataWidth-1:0] aluResult;

    function automatic logic [dataWidth-1:0] pickOperand(
        input fwdSel_t              sel,
        input logic [dataWidth-1:0] regVal,
        input logic [dataWidth-1:0] memVal,
        input logic [dataWidth-1:0] wbVal
    );
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Operands and ALU
    ////////////////////////////////////////////////////////////

    always_comb begin
        srcA = pickOperand(fwdA, rd1E, em.aluOut, resultW);
        srcB = pickOperand(fwdB, rd2E, em.aluOut, resultW);
    end

    assign aluB = useImmE ? immE : srcB;

    always_comb begin
        case (aluOpE)
            opAnd:   aluResult = srcA & aluB;
            opSub:   aluResult = srcA - aluB;
            opAdd:   aluResult = srcA + aluB;
            opOrr:   aluResult = srcA | aluB;
            // MOV ignores Rn
            opMov:   aluResult = aluB;
            default: aluResult = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Execute/memory register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (rst) begin
            em.regWrite <= 1'b0;
            em.memWrite <= 1'b0;
            em.memToReg <= 1'b0;
        end else begin
            em.regWrite <= regWriteE;
            em.memWrite <= memWriteE;
            em.memToReg <= memToRegE;
        end
    end

    always_ff @(posedge CLK) begin
        em.aluOut    <= aluResult;
        em.writeData <= srcB;
        em.wa3       <= wa3E;
        em.ra2       <= ra2E;
    end

endmodule

//--- src/fetchStage.sv
`timescale 1ns/1ps

module fetchStage import armPkg::*; (
    input  logic                 CLK,
    input  logic                 rst,
    input  logic                 stall,
    output logic [dataWidth-1:0] instrAddr,
    input  logic [dataWidth-1:0] instr,
    output instrWord_t           instrD
);

    logic [dataWidth-1:0] pc;

    assign instrAddr = pc;

    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc + dataWidth'(4);
        end
    end

    // Fetch/decode register
    always_ff @(posedge CLK) begin
        if (rst) begin
            instrD <= nopInstr;
        end else if (!stall) begin
            instrD <= instr;
        end
    end

endmodule

//--- src/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import armPkg::*; (
    input  logic [regAddrWidth-1:0] ra1D,
    input  logic [regAddrWidth-1:0] ra2D,
    input  logic [regAddrWidth-1:0] ra1E,
    input  logic [regAddrWidth-1:0] ra2E,
    input  logic [regAddrWidth-1:0] wa3E,
    input  logic                    memToRegE,
    input  logic                    regWriteM,
    input  logic [regAddrWidth-1:0] wa3M,
    input  logic                    regWriteW,
    input  logic [regAddrWidth-1:0] wa3W,
    input  logic [regAddrWidth-1:0] ra2M,
    input  logic                    memWriteM,
    output fwdSel_t                 fwdA,
    output fwdSel_t                 fwdB,
    output logic                    fwdStore,
    output logic                    stall,
    output logic                    bubble
);

    // Newest producer first
    function automatic fwdSel_t fwdFor(input logic [regAddrWidth-1:0] ra);
        if (regWriteM && wa3M == ra) begin
            return fwdMem;
        end else if (regWriteW && wa3W == ra) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    always_comb begin
        fwdA     = fwdFor(ra1E);
        fwdB     = fwdFor(ra2E);
        fwdStore = memWriteM && regWriteW && wa3W == ra2M;
        // Load result not ready for the next instruction
        stall    = memToRegE && (wa3E == ra1D || wa3E == ra2D);
        bubble   = stall;
    end

endmodule

//--- src/memoryStage.sv
`timescale 1ns/1ps

module memoryStage import armPkg::*; (
    input  logic                    CLK,
    input  logic                    rst,
    execMemBus.consumer             em,
    input  logic                    fwdStore,
    output logic [dataWidth-1:0]    ioAddr,
    output logic [dataWidth-1:0]    ioWdata,
    output logic                    ioWe,
    input  logic [dataWidth-1:0]    ioRdata,
    output logic                    regWriteW,
    output logic [regAddrWidth-1:0] wa3W,
    output logic [dataWidth-1:0]    resultW
);

    logic                     isIo;
    logic [dataWidth-1:0]     storeData;
    logic [dataWidth-1:0]     readData;
    logic [dmemAddrWidth-1:0] wordIdx;
    logic [dataWidth-1:0]     dmem [dmemWords];
    logic                     memToRegW;
    logic [dataWidth-1:0]     readDataW;
    logic [dataWidth-1:0]     aluOutW;

    assign storeData = fwdStore ? resultW : em.writeData;
    assign isIo      = em.aluOut >= ioBase;
    assign wordIdx   = em.aluOut[dmemAddrWidth+1:2];

    assign ioAddr  = em.aluOut;
    assign ioWdata = storeData;
    assign ioWe    = em.memWrite && isIo;

    ////////////////////////////////////////////////////////////
    // Data memory
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (em.memWrite && !isIo) begin
            dmem[wordIdx] <= storeData;
        end
    end

    assign readData = isIo ? ioRdata : dmem[wordIdx];

    ////////////////////////////////////////////////////////////
    // Memory/writeback register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (rst) begin
            regWriteW <= 1'b0;
            memToRegW <= 1'b0;
        end else begin
            regWriteW <= em.regWrite;
            memToRegW <= em.memToReg;
        end
    end

    always_ff @(posedge CLK) begin
        readDataW <= readData;
        aluOutW   <= em.aluOut;
        wa3W      <= em.wa3;
    end

    assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

//--- tests/armModel.svh
`ifndef ARM_MODEL_SVH
`define ARM_MODEL_SVH

function automatic instrWord_t dpImm(aluOp_t op, logic [3:0] rd, logic [3:0] rn, logic [7:0] imm);
    instrWord_t w;
    w = '0;
    w.dp.cond     = 4'hE;
    w.dp.opClass  = opClassData;
    w.dp.immFlag  = 1'b1;
    w.dp.opcode   = op;
    w.dp.rn       = rn;
    w.dp.rd       = rd;
    w.dp.operand2 = {4'h0, imm};
    return w;
endfunction

function automatic instrWord_t dpReg(aluOp_t op, logic [3:0] rd, logic [3:0] rn, logic [3:0] rm);
    instrWord_t w;
    w = '0;
    w.dp.cond     = 4'hE;
    w.dp.opClass  = opClassData;
    w.dp.opcode   = op;
    w.dp.rn       = rn;
    w.dp.rd       = rd;
    w.dp.operand2 = {8'h00, rm};
    return w;
endfunction

function automatic instrWord_t memOp(logic load, logic up, logic [3:0] rd, logic [3:0] rn,
                                     logic [11:0] off);
    instrWord_t w;
    w = '0;
    w.mem.cond    = 4'hE;
    w.mem.opClass = opClassMem;
    w.mem.pre     = 1'b1;
    w.mem.up      = up;
    w.mem.load    = load;
    w.mem.rn      = rn;
    w.mem.rd      = rd;
    w.mem.offset  = off;
    return w;
endfunction

// Architectural run of the program, one instruction at a time
task automatic predictIo();
    logic [31:0] regs [numRegs];
    logic [31:0] dmemModel [logic [7:0]];
    instrWord_t  w;
    logic [31:0] opB;
    logic [31:0] addr;
    for (int i = 0; i < progLen; i++) begin
        w = prog[i];
        if (w.dp.opClass == opClassData) begin
            opB = w.dp.immFlag ? {24'h0, w.dp.operand2[7:0]} : regs[w.dp.operand2[3:0]];
            case (w.dp.opcode)
                opAnd: regs[w.dp.rd] = regs[w.dp.rn] & opB;
                opSub: regs[w.dp.rd] = regs[w.dp.rn] - opB;
                opAdd: regs[w.dp.rd] = regs[w.dp.rn] + opB;
                opOrr: regs[w.dp.rd] = regs[w.dp.rn] | opB;
                default: regs[w.dp.rd] = opB;
            endcase
        end else begin
            addr = w.mem.up ? regs[w.mem.rn] + w.mem.offset : regs[w.mem.rn] - w.mem.offset;
            if (w.mem.load) begin
                regs[w.mem.rd] = (addr >= ioBase) ? ioValue : dmemModel[addr[9:2]];
            end else if (addr >= ioBase) begin
                expAddr.push_back(addr);
                expData.push_back(regs[w.mem.rd]);
            end else begin
                dmemModel[addr[9:2]] = regs[w.mem.rd];
            end
        end
    end
endtask

`endif

//--- tests/armCoreTb.sv
`timescale 1ns/1ps

module armCoreTb import armPkg::*; ();

    logic        CLK;
    logic        rst;
    logic [31:0] instrAddr;
    logic [31:0] instr;
    logic [31:0] ioAddr;
    logic [31:0] ioWdata;
    logic        ioWe;
    logic [31:0] ioRdata;

    instrWord_t  prog [64];
    int          progLen;
    integer      seed;
    logic [31:0] ioValue;
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    int          errors;
    int          checks;
    int          cycles;
    int          holds;
    logic [31:0] prevAddr;

    `include "armModel.svh"

    armCore dut0 (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // ROM-like program port
    assign instr = (instrAddr[31:2] < progLen) ? prog[instrAddr[7:2]] : nopInstr;

    task automatic emit(instrWord_t w);
        prog[progLen] = w;
        progLen++;
    endtask

    ////////////////////////////////////////////////////////////
    // Program
    ////////////////////////////////////////////////////////////

    task automatic buildProgram();
        logic [11:0] dOff;
        dOff = 12'($random(seed)) & 12'h3FC;
        emit(dpImm(opMov, 1, 0, 8'($random(seed))));
        emit(dpImm(opMov, 2, 0, 8'($random(seed))));
        emit(dpReg(opAdd, 3, 1, 2));
        emit(dpImm(opMov, 4, 0, 8'h00));
        // r4 becomes all ones so IO stores count down from it
        emit(dpImm(opSub, 4, 4, 8'h01));
        emit(memOp(1'b0, 1'b0, 3, 4, 12'd3));
        emit(dpReg(opSub, 5, 3, 1));
        emit(dpImm(opAnd, 6, 5, 8'($random(seed))));
        emit(dpReg(opOrr, 7, 6, 5));
        emit(memOp(1'b0, 1'b0, 7, 4, 12'd7));
        emit(dpReg(opMov, 8, 0, 7));
        emit(dpImm(opAdd, 8, 8, 8'($random(seed))));
        emit(memOp(1'b0, 1'b0, 8, 4, 12'd11));
        emit(dpImm(opOrr, 9, 1, 8'($random(seed))));
        emit(dpReg(opSub, 9, 9, 2));
        emit(memOp(1'b0, 1'b0, 9, 4, 12'd15));
        // Data memory round trip
        emit(dpImm(opMov, 10, 0, 8'($random(seed))));
        emit(memOp(1'b0, 1'b1, 9, 10, dOff));
        emit(dpImm(opMov, 11, 0, 8'h00));
        emit(memOp(1'b1, 1'b1, 11, 10, dOff));
        emit(memOp(1'b0, 1'b0, 11, 4, 12'd19));
        emit(memOp(1'b1, 1'b1, 12, 10, dOff));
        emit(dpReg(opAdd, 12, 12, 1));
        emit(memOp(1'b0, 1'b0, 12, 4, 12'd23));
        // Load from IO
        emit(memOp(1'b1, 1'b0, 5, 4, 12'd31));
        emit(dpImm(opMov, 6, 0, 8'h01));
        emit(dpReg(opAdd, 6, 5, 6));
        emit(memOp(1'b0, 1'b0, 6, 4, 12'd27));
        emit(memOp(1'b0, 1'b0, 5, 4, 12'd35));
        emit(dpReg(opAdd, 7, 7, 7));
        emit(dpImm(opSub, 7, 7, 8'($random(seed))));
        emit(dpReg(opAnd, 8, 7, 3));
        emit(memOp(1'b0, 1'b0, 8, 4, 12'd39));
        emit(dpImm(opMov, 9, 0, 8'($random(seed))));
        emit(dpReg(opOrr, 9, 9, 12));
        emit(memOp(1'b0, 1'b0, 9, 4, 12'd43));
        emit(dpReg(opSub, 3, 3, 3));
        emit(memOp(1'b0, 1'b0, 3, 4, 12'd47));
    endtask

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    always @(posedge CLK) begin
        if (!rst) begin
            cycles <= cycles + 1;
        end
    end

    always @(negedge CLK) begin
        if (!rst) begin
            checks++;
            assert (instrAddr - prevAddr == 0 || instrAddr - prevAddr == 4) else begin
                errors++;
                $display("[FAIL] pcStep expected %h or %h actual %h", prevAddr, prevAddr + 4,
                         instrAddr);
            end
            if (instrAddr == prevAddr && instrAddr < progLen * 4) begin
                holds++;
            end
            prevAddr = instrAddr;
            if (ioWe) begin
                if (expAddr.size() == 0) begin
                    errors++;
                    $display("IO write to %h with no write left in the expected queue", ioAddr);
                end else begin
                    checks++;
                    assert (ioAddr === expAddr[0]) else begin
                        errors++;
                        $display("[FAIL] ioAddr expected %h actual %h", expAddr[0], ioAddr);
                    end
                    assert (ioWdata === expData[0]) else begin
                        errors++;
                        $display("[FAIL] ioWdata expected %h actual %h", expData[0], ioWdata);
                    end
                    void'(expAddr.pop_front());
                    void'(expData.pop_front());
                end
            end
        end
    end

    initial begin
        rst      = 1'b1;
        ioRdata  = '0;
        seed     = 32'hcc46;
        progLen  = 0;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        holds    = 0;
        // One step before the first fetch address
        prevAddr = 32'hFFFF_FFFC;
        ioValue  = $random(seed);
        buildProgram();
        predictIo();
        repeat (7) @(posedge CLK);
        @(negedge CLK);
        checks++;
        assert (ioWe === 1'b0 && instrAddr === 32'h0) else begin
            errors++;
            $display("[FAIL] reset expected ioWe 0 addr 0 actual ioWe %b addr %h", ioWe, instrAddr);
        end
        @(posedge CLK);
        rst     <= 1'b0;
        ioRdata <= ioValue;
        while (cycles < 2 * progLen + 40 && !(expAddr.size() == 0 && instrAddr >= progLen * 4)) begin
            @(negedge CLK);
        end
        if (expAddr.size() != 0) begin
            errors++;
            $display("Timeout after %0d cycles, the IO queue was not drained (%0d left)", cycles,
                     expAddr.size());
        end else begin
            repeat (8) @(negedge CLK);
        end
        if (holds == 0) begin
            errors++;
            $display("The load-use stall never held the fetch address");
        end
        $display("Checks: %0d, errors: %0d, fetch holds: %0d", checks, errors, holds);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
